// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu6502
RTL_TOP   ?= cpu6502
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= TEST PASS

SOURCES := $(shell grep -v '^+' $(FLIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
hw/cpu6502_pkg.sv
hw/alu.sv
hw/timing_control.sv
hw/instr_decoder.sv
hw/program_counter.sv
hw/datapath.sv
hw/cpu6502.sv
testbench/tb_cpu6502.sv

// ==== hw/alu.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu (
    input  wire cpu6502_pkg::alu_op_e            i_op,
    input  wire logic [cpu6502_pkg::DATA_W-1:0]  i_a,
    input  wire logic [cpu6502_pkg::DATA_W-1:0]  i_b,
    input  wire logic                            i_carry,
    output logic [cpu6502_pkg::DATA_W-1:0]       o_result,
    output logic                                 o_carry,
    output logic                                 o_overflow
);

    import cpu6502_pkg::*;

    logic [DATA_W-1:0] sum;
    logic              sum_carry;

    // Binary add only
    assign {sum_carry, sum} = {1'b0, i_a} + {1'b0, i_b} + (DATA_W + 1)'(i_carry);

    always_comb begin
        o_carry    = 1'b0;
        o_overflow = 1'b0;
        case (i_op)
            ALU_SUM: begin
                o_result   = sum;
                o_carry    = sum_carry;
                // Like signs in, other sign out
                o_overflow = (i_a[DATA_W-1] == i_b[DATA_W-1]) &&
                             (sum[DATA_W-1] != i_a[DATA_W-1]);
            end
            ALU_AND: begin
                o_result = i_a & i_b;
            end
            ALU_OR: begin
                o_result = i_a | i_b;
            end
            ALU_EOR: begin
                o_result = i_a ^ i_b;
            end
            default: begin
                o_result = i_b;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/cpu6502.sv ====
`timescale 1ns/1ns
`default_nettype none

module cpu6502 (
    input  wire logic                            i_clk,
    input  wire logic                            i_rst_n,
    input  wire logic [cpu6502_pkg::DATA_W-1:0]  i_data,
    output logic [cpu6502_pkg::ADDR_W-1:0]       o_address,
    output logic                                 o_rw,
    output logic [cpu6502_pkg::DATA_W-1:0]       o_data,
    output logic                                 o_sync,
    output cpu6502_pkg::debug_t                  o_debug
);

    import cpu6502_pkg::*;

    logic [TCU_W-1:0]  tcu;
    logic              last_cycle;
    ctrl_t             ctrl;
    logic [DATA_W-1:0] ir;
    logic [DATA_W-1:0] dl;
    logic [ADDR_W-1:0] pc;
    debug_t            debug_regs;

    timing_control timing_control_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_last_cycle (last_cycle),
        .o_tcu        (tcu)
    );

    instr_decoder instr_decoder_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_tcu        (tcu),
        .i_dl         (dl),
        .o_ctrl       (ctrl),
        .o_last_cycle (last_cycle),
        .o_sync       (o_sync),
        .o_ir         (ir)
    );

    program_counter program_counter_inst (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_ctrl  (ctrl),
        .i_dl    (dl),
        .o_pc    (pc)
    );

    datapath datapath_inst (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_ctrl       (ctrl),
        .i_pc         (pc),
        .i_data       (i_data),
        .o_dl         (dl),
        .o_address    (o_address),
        .o_rw         (o_rw),
        .o_data       (o_data),
        .o_debug_regs (debug_regs)
    );

    assign o_debug = '{a: debug_regs.a, x: debug_regs.x, y: debug_regs.y,
                       p: debug_regs.p, ir: ir, tcu: tcu};

endmodule

`default_nettype wire

// ==== hw/cpu6502_pkg.sv ====
`default_nettype none

package cpu6502_pkg;

    localparam int DATA_W = 8;
    localparam int ADDR_W = 16;
    localparam int TCU_W  = 3;

    // Reset vector low byte with the high byte after it
    localparam logic [ADDR_W-1:0] RESET_VEC = 16'hFFFC;

    // Supported opcodes
    localparam logic [DATA_W-1:0] OP_LDA_IMM = 8'hA9;
    localparam logic [DATA_W-1:0] OP_LDX_IMM = 8'hA2;
    localparam logic [DATA_W-1:0] OP_LDY_IMM = 8'hA0;
    localparam logic [DATA_W-1:0] OP_ADC_IMM = 8'h69;
    localparam logic [DATA_W-1:0] OP_AND_IMM = 8'h29;
    localparam logic [DATA_W-1:0] OP_ORA_IMM = 8'h09;
    localparam logic [DATA_W-1:0] OP_EOR_IMM = 8'h49;
    localparam logic [DATA_W-1:0] OP_TAX     = 8'hAA;
    localparam logic [DATA_W-1:0] OP_INX     = 8'hE8;
    localparam logic [DATA_W-1:0] OP_NOP     = 8'hEA;
    localparam logic [DATA_W-1:0] OP_STA_ZP  = 8'h85;
    localparam logic [DATA_W-1:0] OP_STA_ABS = 8'h8D;
    localparam logic [DATA_W-1:0] OP_JMP_ABS = 8'h4C;

    typedef enum logic [2:0] {ALU_SUM, ALU_AND, ALU_OR, ALU_EOR, ALU_PASS} alu_op_e;

    typedef enum logic [1:0] {ADDR_PC, ADDR_DL_ZP, ADDR_DL_ABS, ADDR_VEC} addr_src_e;

    typedef enum logic [1:0] {SB_A, SB_X, SB_ADD, SB_DL} sb_src_e;

    // One cycle worth of control decoded from IR and TCU
    typedef struct packed {
        logic      pc_inc;
        logic      pc_load_lo;
        logic      pc_load_hi;
        addr_src_e addr_src;
        logic      vec_hi;
        logic      latch_lo;
        sb_src_e   sb_src;
        logic      load_a;
        logic      load_x;
        logic      load_y;
        alu_op_e   alu_op;
        logic      alu_b_one;
        logic      carry_in_c;
        logic      set_nz;
        logic      set_cv;
        logic      write;
    } ctrl_t;

    typedef struct packed {
        logic n;
        logic v;
        logic unused;
        logic b;
        logic d;
        logic i;
        logic z;
        logic c;
    } status_flags_t;

    // P register seen as flags or as a plain byte
    typedef union packed {
        status_flags_t             flags;
        logic [DATA_W-1:0]         raw;
    } status_u;

    typedef struct packed {
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] x;
        logic [DATA_W-1:0] y;
        status_u           p;
        logic [DATA_W-1:0] ir;
        logic [TCU_W-1:0]  tcu;
    } debug_t;

endpackage

`default_nettype wire

// ==== hw/datapath.sv ====
`timescale 1ns/1ns
`default_nettype none

module datapath (
    input  wire logic                            i_clk,
    input  wire logic                            i_rst_n,
    input  wire cpu6502_pkg::ctrl_t              i_ctrl,
    input  wire logic [cpu6502_pkg::ADDR_W-1:0]  i_pc,
    input  wire logic [cpu6502_pkg::DATA_W-1:0]  i_data,
    output logic [cpu6502_pkg::DATA_W-1:0]       o_dl,
    output logic [cpu6502_pkg::ADDR_W-1:0]       o_address,
    output logic                                 o_rw,
    output logic [cpu6502_pkg::DATA_W-1:0]       o_data,
    output cpu6502_pkg::debug_t                  o_debug_regs
);

    import cpu6502_pkg::*;

    logic [DATA_W-1:0] dl_q;
    logic [DATA_W-1:0] dl;
    logic [DATA_W-1:0] adl_q;
    logic [DATA_W-1:0] dor_q;
    logic [DATA_W-1:0] a_q;
    logic [DATA_W-1:0] x_q;
    logic [DATA_W-1:0] y_q;
    status_u           p_q;
    logic [DATA_W-1:0] sb;
    logic [DATA_W-1:0] alu_a;
    logic [DATA_W-1:0] alu_b;
    logic [DATA_W-1:0] alu_result;
    logic              alu_carry;
    logic              alu_overflow;

    // Input data latch opens on read cycles
    always_ff @(posedge i_clk) begin
        if (!i_ctrl.write) begin
            dl_q <= i_data;
        end
        if (i_ctrl.latch_lo) begin
            adl_q <= dl;
        end
        dor_q <= a_q;
    end

    assign dl = i_ctrl.write ? dl_q : i_data;

    // INX works on X and everything else on A
    assign alu_a = i_ctrl.load_x ? x_q : a_q;
    assign alu_b = i_ctrl.alu_b_one ? DATA_W'(1) : dl;

    alu alu_inst (
        .i_op       (i_ctrl.alu_op),
        .i_a        (alu_a),
        .i_b        (alu_b),
        .i_carry    (i_ctrl.carry_in_c & p_q.flags.c),
        .o_result   (alu_result),
        .o_carry    (alu_carry),
        .o_overflow (alu_overflow)
    );

    always_comb begin
        case (i_ctrl.sb_src)
            SB_A:    sb = a_q;
            SB_X:    sb = x_q;
            SB_ADD:  sb = alu_result;
            default: sb = dl;
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            a_q     <= '0;
            x_q     <= '0;
            y_q     <= '0;
            p_q.raw <= '0;
        end else begin
            if (i_ctrl.load_a) begin
                a_q <= sb;
            end
            if (i_ctrl.load_x) begin
                x_q <= sb;
            end
            if (i_ctrl.load_y) begin
                y_q <= sb;
            end
            if (i_ctrl.set_nz) begin
                p_q.flags.n <= sb[DATA_W-1];
                p_q.flags.z <= (sb == '0);
            end
            if (i_ctrl.set_cv) begin
                p_q.flags.c <= alu_carry;
                p_q.flags.v <= alu_overflow;
            end
        end
    end

    always_comb begin
        case (i_ctrl.addr_src)
            ADDR_PC:     o_address = i_pc;
            ADDR_DL_ZP:  o_address = {{DATA_W{1'b0}}, dl_q};
            ADDR_DL_ABS: o_address = {dl_q, adl_q};
            default:     o_address = RESET_VEC | ADDR_W'(i_ctrl.vec_hi);
        endcase
    end

    assign o_dl   = dl;
    assign o_rw   = ~i_ctrl.write;
    assign o_data = dor_q;

    // IR and TCU are filled in by the top level
    assign o_debug_regs = '{a: a_q, x: x_q, y: y_q, p: p_q, ir: '0, tcu: '0};

endmodule

`default_nettype wire

// ==== hw/instr_decoder.sv ====
`timescale 1ns/1ns
`default_nettype none

module instr_decoder (
    input  wire logic                          i_clk,
    input  wire logic                          i_rst_n,
    input  wire logic [cpu6502_pkg::TCU_W-1:0] i_tcu,
    input  wire logic [cpu6502_pkg::DATA_W-1:0] i_dl,
    output cpu6502_pkg::ctrl_t                 o_ctrl,
    output logic                               o_last_cycle,
    output logic                               o_sync,
    output logic [cpu6502_pkg::DATA_W-1:0]     o_ir
);

    import cpu6502_pkg::*;

    typedef enum logic [1:0] {RST_LO, RST_HI, RUN} state_e;

    state_e            state_q;
    logic [DATA_W-1:0] ir_q;
    ctrl_t             ctrl;
    logic              last_cycle;
    logic              sync;

    // Vector fetch runs once after reset
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state_q <= RST_LO;
        end else begin
            case (state_q)
                RST_LO:  state_q <= RST_HI;
                default: state_q <= RUN;
            endcase
        end
    end

    // Opcode is captured at the end of T0
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            ir_q <= '0;
        end else if (state_q == RUN && i_tcu == '0) begin
            ir_q <= i_dl;
        end
    end

    always_comb begin
        ctrl          = '0;
        ctrl.addr_src = ADDR_PC;
        ctrl.sb_src   = SB_DL;
        ctrl.alu_op   = ALU_PASS;
        last_cycle    = 1'b0;
        sync          = 1'b0;

        case (state_q)
            RUN: begin
                if (i_tcu == '0) begin
                    sync        = 1'b1;
                    ctrl.pc_inc = 1'b1;
                end else begin
                    case (ir_q)
                        OP_LDA_IMM: begin
                            ctrl.pc_inc = 1'b1;
                            ctrl.load_a = 1'b1;
                            ctrl.set_nz = 1'b1;
                            last_cycle  = 1'b1;
                        end
                        OP_LDX_IMM: begin
                            ctrl.pc_inc = 1'b1;
                            ctrl.load_x = 1'b1;
                            ctrl.set_nz = 1'b1;
                            last_cycle  = 1'b1;
                        end
                        OP_LDY_IMM: begin
                            ctrl.pc_inc = 1'b1;
                            ctrl.load_y = 1'b1;
                            ctrl.set_nz = 1'b1;
                            last_cycle  = 1'b1;
                        end
                        OP_ADC_IMM: begin
                            ctrl.pc_inc     = 1'b1;
                            ctrl.sb_src     = SB_ADD;
                            ctrl.alu_op     = ALU_SUM;
                            ctrl.carry_in_c = 1'b1;
                            ctrl.load_a     = 1'b1;
                            ctrl.set_nz     = 1'b1;
                            ctrl.set_cv     = 1'b1;
                            last_cycle      = 1'b1;
                        end
                        OP_AND_IMM, OP_ORA_IMM, OP_EOR_IMM: begin
                            ctrl.pc_inc = 1'b1;
                            ctrl.sb_src = SB_ADD;
                            ctrl.alu_op = (ir_q == OP_AND_IMM) ? ALU_AND :
                                          (ir_q == OP_ORA_IMM) ? ALU_OR : ALU_EOR;
                            ctrl.load_a = 1'b1;
                            ctrl.set_nz = 1'b1;
                            last_cycle  = 1'b1;
                        end
                        OP_TAX: begin
                            ctrl.sb_src = SB_A;
                            ctrl.load_x = 1'b1;
                            ctrl.set_nz = 1'b1;
                            last_cycle  = 1'b1;
                        end
                        OP_INX: begin
                            ctrl.sb_src    = SB_ADD;
                            ctrl.alu_op    = ALU_SUM;
                            ctrl.alu_b_one = 1'b1;
                            ctrl.load_x    = 1'b1;
                            ctrl.set_nz    = 1'b1;
                            last_cycle     = 1'b1;
                        end
                        OP_STA_ZP: begin
                            if (i_tcu == TCU_W'(1)) begin
                                ctrl.pc_inc = 1'b1;
                            end else begin
                                ctrl.addr_src = ADDR_DL_ZP;
                                ctrl.write    = 1'b1;
                                last_cycle    = 1'b1;
                            end
                        end
                        OP_STA_ABS: begin
                            // T1 low byte, T2 high byte, T3 store
                            if (i_tcu == TCU_W'(1)) begin
                                ctrl.pc_inc   = 1'b1;
                                ctrl.latch_lo = 1'b1;
                            end else if (i_tcu == TCU_W'(2)) begin
                                ctrl.pc_inc = 1'b1;
                            end else begin
                                ctrl.addr_src = ADDR_DL_ABS;
                                ctrl.write    = 1'b1;
                                last_cycle    = 1'b1;
                            end
                        end
                        OP_JMP_ABS: begin
                            if (i_tcu == TCU_W'(1)) begin
                                ctrl.pc_inc     = 1'b1;
                                ctrl.pc_load_lo = 1'b1;
                            end else begin
                                ctrl.pc_load_hi = 1'b1;
                                last_cycle      = 1'b1;
                            end
                        end
                        OP_NOP: begin
                            last_cycle = 1'b1;
                        end
                        default: begin
                            // Unknown opcodes run as NOP
                            last_cycle = 1'b1;
                        end
                    endcase
                end
            end
            RST_HI: begin
                ctrl.addr_src   = ADDR_VEC;
                ctrl.vec_hi     = 1'b1;
                ctrl.pc_load_hi = 1'b1;
                last_cycle      = 1'b1;
            end
            default: begin
                ctrl.addr_src   = ADDR_VEC;
                ctrl.pc_load_lo = 1'b1;
                last_cycle      = 1'b1;
            end
        endcase
    end

    assign o_ctrl       = ctrl;
    assign o_last_cycle = last_cycle;
    assign o_sync       = sync;
    assign o_ir         = ir_q;

endmodule

`default_nettype wire

// ==== hw/program_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module program_counter (
    input  wire logic                           i_clk,
    input  wire logic                           i_rst_n,
    input  wire cpu6502_pkg::ctrl_t             i_ctrl,
    input  wire logic [cpu6502_pkg::DATA_W-1:0] i_dl,
    output logic [cpu6502_pkg::ADDR_W-1:0]      o_pc
);

    import cpu6502_pkg::*;

    logic [DATA_W-1:0] pcl_q;
    logic [DATA_W-1:0] pch_q;
    // Low byte waits here until the high byte arrives
    logic [DATA_W-1:0] adl_hold_q;
    logic [DATA_W-1:0] pcl_inc;
    logic              pclc;

    assign {pclc, pcl_inc} = {1'b0, pcl_q} + (DATA_W + 1)'(1);

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            pcl_q      <= '0;
            pch_q      <= '0;
            adl_hold_q <= '0;
        end else begin
            if (i_ctrl.pc_load_lo) begin
                adl_hold_q <= i_dl;
            end
            // A full load wins over the increment
            if (i_ctrl.pc_load_hi) begin
                pcl_q <= adl_hold_q;
                pch_q <= i_dl;
            end else if (i_ctrl.pc_inc) begin
                pcl_q <= pcl_inc;
                pch_q <= pch_q + DATA_W'(pclc);
            end
        end
    end

    assign o_pc = {pch_q, pcl_q};

endmodule

`default_nettype wire

// ==== hw/timing_control.sv ====
`timescale 1ns/1ns
`default_nettype none

module timing_control (
    input  wire logic                          i_clk,
    input  wire logic                          i_rst_n,
    input  wire logic                          i_last_cycle,
    output logic [cpu6502_pkg::TCU_W-1:0]      o_tcu
);

    import cpu6502_pkg::*;

    logic [TCU_W-1:0] tcu_q;

    // T0 is always the opcode fetch
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            tcu_q <= '0;
        end else if (i_last_cycle) begin
            tcu_q <= '0;
        end else begin
            tcu_q <= tcu_q + TCU_W'(1);
        end
    end

    assign o_tcu = tcu_q;

endmodule

`default_nettype wire

// ==== testbench/tb_cpu6502.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_cpu6502;

    import cpu6502_pkg::*;

    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;
    // Five tests of at most 80 cycles each with a margin of five
    localparam int TEST_COUNT      = 5;
    localparam int CYCLES_PER_TEST = 80;
    localparam int CYCLE_LIMIT     = TEST_COUNT * CYCLES_PER_TEST * 5;

    logic              i_clk;
    logic              i_rst_n;
    logic [DATA_W-1:0] i_data;
    logic [ADDR_W-1:0] o_address;
    logic              o_rw;
    logic [DATA_W-1:0] o_data;
    logic              o_sync;
    debug_t            o_debug;

    logic [DATA_W-1:0] mem [0:(1 << ADDR_W) - 1];

    integer            seed = 32'h3567_7d28;
    int                cycle_count = 0;
    int                error_count = 0;
    int                pass_count = 0;
    int                fail_count = 0;
    int                last_sync_cycle = 0;
    int                sync_gap = 0;
    int                write_count = 0;
    logic [ADDR_W-1:0] write_addr;
    logic [DATA_W-1:0] write_data;
    logic [ADDR_W-1:0] prog_ptr;
    logic [ADDR_W-1:0] start_addr;
    logic [TCU_W-1:0]  last_tcu;
    logic [DATA_W-1:0] exp_a;
    logic [DATA_W-1:0] exp_x;
    logic [DATA_W-1:0] exp_y;
    logic [DATA_W-1:0] exp_ir;
    status_u           exp_p;

    cpu6502 cpu6502_inst (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_data    (i_data),
        .o_address (o_address),
        .o_rw      (o_rw),
        .o_data    (o_data),
        .o_sync    (o_sync),
        .o_debug   (o_debug)
    );

    // Asynchronous read with the store at the end of a write cycle
    assign i_data = mem[o_address];

    always @(posedge i_clk) begin
        if (o_rw === 1'b0) begin
            mem[o_address] <= o_data;
        end
    end

    // Remember the last write cycle seen mid-cycle
    always @(negedge i_clk) begin
        if (o_rw === 1'b0) begin
            write_count = write_count + 1;
            write_addr  = o_address;
            write_data  = o_data;
        end
    end

    initial begin
        i_clk = 1'b0;
        forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: the run passed %0d cycles without finishing", cycle_count);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_byte(input string name, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] expected,
                              input logic [ADDR_W-1:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_status(input string name, input status_u expected,
                                input status_u actual);
        if (actual.raw !== expected.raw) begin
            $display("CHECK FAILED %s expected %h actual %h", name, expected.raw, actual.raw);
            error_count++;
        end
    endtask

    function automatic logic [DATA_W-1:0] rand_byte();
        return DATA_W'($random(seed));
    endfunction

    task automatic fill_memory();
        for (int i = 0; i < (1 << ADDR_W); i++) begin
            mem[ADDR_W'(i)] <= DATA_W'(i[7:0] ^ i[15:8] ^ 8'h5A);
        end
    endtask

    task automatic set_vector(input logic [ADDR_W-1:0] vec);
        mem[RESET_VEC]              <= vec[7:0];
        mem[RESET_VEC + ADDR_W'(1)] <= vec[15:8];
        prog_ptr   = vec;
        start_addr = vec;
    endtask

    task automatic emit(input logic [DATA_W-1:0] value);
        mem[prog_ptr] <= value;
        prog_ptr = prog_ptr + ADDR_W'(1);
    endtask

    task automatic emit_jmp(input logic [ADDR_W-1:0] target);
        emit(OP_JMP_ABS);
        emit(target[7:0]);
        emit(target[15:8]);
    endtask

    // Jump to itself so the core never runs into the fill bytes
    task automatic emit_halt();
        logic [ADDR_W-1:0] here;
        here = prog_ptr;
        emit_jmp(here);
    endtask

    task automatic begin_reset();
        @(posedge i_clk);
        #DRIVE_DELAY;
        i_rst_n = 1'b0;
    endtask

    task automatic end_reset();
        repeat (4) begin
            @(negedge i_clk);
            check_bit("o_rw", 1'b1, o_rw);
            check_bit("o_sync", 1'b0, o_sync);
        end
        @(posedge i_clk);
        #DRIVE_DELAY;
        i_rst_n   = 1'b1;
        exp_a     = '0;
        exp_x     = '0;
        exp_y     = '0;
        exp_p.raw = '0;
        // First opcode shows in IR at the second fetch
        exp_ir    = mem[start_addr];
    endtask

    task automatic next_sync();
        @(negedge i_clk);
        while (o_sync !== 1'b1) begin
            last_tcu = o_debug.tcu;
            @(negedge i_clk);
        end
        sync_gap        = cycle_count - last_sync_cycle;
        last_sync_cycle = cycle_count;
    endtask

    task automatic update_nz(input logic [DATA_W-1:0] value);
        exp_p.flags.n = value[DATA_W-1];
        exp_p.flags.z = (value == '0);
    endtask

    // Binary add with the C flag as carry in
    task automatic model_adc(input logic [DATA_W-1:0] operand);
        int unsigned_sum;
        int signed_sum;
        unsigned_sum = int'(exp_a) + int'(operand) + int'(exp_p.flags.c);
        signed_sum   = int'($signed(exp_a)) + int'($signed(operand)) + int'(exp_p.flags.c);
        // V when the signed sum leaves the range of a signed byte
        exp_p.flags.v = (signed_sum > 127) || (signed_sum < -128);
        exp_p.flags.c = (unsigned_sum > 255);
        exp_a = DATA_W'(unsigned_sum);
        update_nz(exp_a);
    endtask

    task automatic expect_regs();
        check_byte("A", exp_a, o_debug.a);
        check_byte("X", exp_x, o_debug.x);
        check_byte("Y", exp_y, o_debug.y);
        check_status("P", exp_p, o_debug.p);
    endtask

    task automatic expect_fetch(input logic [ADDR_W-1:0] addr, input int gap);
        next_sync();
        check_addr("o_address", addr, o_address);
        check_byte("o_sync spacing", DATA_W'(gap), DATA_W'(sync_gap));
        check_byte("o_debug.tcu before fetch", DATA_W'(gap - 1), DATA_W'(last_tcu));
        check_byte("o_debug.ir", exp_ir, o_debug.ir);
        expect_regs();
        exp_ir = mem[addr];
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (error_count == errors_before) begin
            pass_count++;
            $display("passed: %s", name);
        end else begin
            fail_count++;
            $display("failed: %s (%0d errors)", name, error_count - errors_before);
        end
    endtask

    task automatic test_reset_vector();
        int                errors_before;
        logic [ADDR_W-1:0] vec;
        errors_before = error_count;
        vec = 16'hC123;
        begin_reset();
        fill_memory();
        set_vector(vec);
        emit_halt();
        end_reset();
        // Vector low byte then high byte
        @(negedge i_clk);
        check_addr("o_address", RESET_VEC, o_address);
        check_bit("o_rw", 1'b1, o_rw);
        check_bit("o_sync", 1'b0, o_sync);
        @(negedge i_clk);
        check_addr("o_address", RESET_VEC + ADDR_W'(1), o_address);
        check_bit("o_rw", 1'b1, o_rw);
        check_bit("o_sync", 1'b0, o_sync);
        @(negedge i_clk);
        check_bit("o_sync", 1'b1, o_sync);
        check_addr("o_address", vec, o_address);
        expect_regs();
        report_test("reset vector", errors_before);
    endtask

    task automatic test_loads_transfers();
        int                errors_before;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] x;
        logic [DATA_W-1:0] y;
        errors_before = error_count;
        a = rand_byte();
        x = rand_byte();
        y = rand_byte();
        begin_reset();
        fill_memory();
        set_vector(16'h0200);
        emit(OP_LDA_IMM);
        emit(a);
        emit(OP_LDX_IMM);
        emit(x);
        emit(OP_LDY_IMM);
        emit(y);
        emit(OP_TAX);
        emit(OP_INX);
        emit(OP_LDX_IMM);
        emit(8'hFF);
        emit(OP_INX);
        emit(OP_LDA_IMM);
        emit(8'h00);
        emit_halt();
        end_reset();
        next_sync();
        expect_regs();
        exp_a = a;
        update_nz(a);
        expect_fetch(16'h0202, 2);
        exp_x = x;
        update_nz(x);
        expect_fetch(16'h0204, 2);
        exp_y = y;
        update_nz(y);
        expect_fetch(16'h0206, 2);
        exp_x = exp_a;
        update_nz(exp_x);
        expect_fetch(16'h0207, 2);
        exp_x = exp_x + DATA_W'(1);
        update_nz(exp_x);
        expect_fetch(16'h0208, 2);
        exp_x = 8'hFF;
        update_nz(exp_x);
        expect_fetch(16'h020A, 2);
        // INX wraps to zero
        exp_x = 8'h00;
        update_nz(exp_x);
        expect_fetch(16'h020B, 2);
        exp_a = 8'h00;
        update_nz(exp_a);
        expect_fetch(16'h020D, 2);
        report_test("loads and transfers", errors_before);
    endtask

    task automatic test_adc();
        int                errors_before;
        logic [DATA_W-1:0] av [4];
        logic [DATA_W-1:0] bv [4];
        errors_before = error_count;
        av[0] = 8'h7F;
        bv[0] = 8'h01;
        av[1] = 8'hFF;
        bv[1] = 8'h01;
        for (int i = 2; i < 4; i++) begin
            av[i] = rand_byte();
            bv[i] = rand_byte();
        end
        begin_reset();
        fill_memory();
        set_vector(16'h0400);
        for (int i = 0; i < 4; i++) begin
            emit(OP_LDA_IMM);
            emit(av[i]);
            emit(OP_ADC_IMM);
            emit(bv[i]);
        end
        emit_halt();
        end_reset();
        next_sync();
        for (int i = 0; i < 4; i++) begin
            exp_a = av[i];
            update_nz(exp_a);
            expect_fetch(16'h0400 + ADDR_W'(4 * i + 2), 2);
            model_adc(bv[i]);
            expect_fetch(16'h0400 + ADDR_W'(4 * i + 4), 2);
        end
        report_test("adc", errors_before);
    endtask

    task automatic test_logic_stores();
        int                errors_before;
        int                writes_before;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] m1;
        logic [DATA_W-1:0] m2;
        logic [DATA_W-1:0] m3;
        logic [DATA_W-1:0] zp;
        logic [ADDR_W-1:0] abs_addr;
        errors_before = error_count;
        a  = rand_byte();
        m1 = rand_byte();
        m2 = rand_byte();
        m3 = rand_byte();
        zp = rand_byte();
        abs_addr = {8'h40 | (rand_byte() & 8'h3F), rand_byte()};
        begin_reset();
        fill_memory();
        set_vector(16'h0300);
        emit(OP_LDA_IMM);
        emit(a);
        emit(OP_AND_IMM);
        emit(m1);
        emit(OP_ORA_IMM);
        emit(m2);
        emit(OP_EOR_IMM);
        emit(m3);
        emit(OP_STA_ZP);
        emit(zp);
        emit(OP_STA_ABS);
        emit(abs_addr[7:0]);
        emit(abs_addr[15:8]);
        emit_halt();
        end_reset();
        next_sync();
        exp_a = a;
        update_nz(exp_a);
        expect_fetch(16'h0302, 2);
        exp_a = exp_a & m1;
        update_nz(exp_a);
        expect_fetch(16'h0304, 2);
        exp_a = exp_a | m2;
        update_nz(exp_a);
        expect_fetch(16'h0306, 2);
        exp_a = exp_a ^ m3;
        update_nz(exp_a);
        expect_fetch(16'h0308, 2);
        writes_before = write_count;
        expect_fetch(16'h030A, 3);
        check_byte("write cycles", 8'd1, DATA_W'(write_count - writes_before));
        check_addr("o_address on write", {8'h00, zp}, write_addr);
        check_byte("o_data", exp_a, write_data);
        check_byte("zero page memory", exp_a, mem[{8'h00, zp}]);
        writes_before = write_count;
        expect_fetch(16'h030D, 4);
        check_byte("write cycles", 8'd1, DATA_W'(write_count - writes_before));
        check_addr("o_address on write", abs_addr, write_addr);
        check_byte("o_data", exp_a, write_data);
        check_byte("absolute memory", exp_a, mem[abs_addr]);
        report_test("logic and stores", errors_before);
    endtask

    task automatic test_jumps_timing();
        int                errors_before;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] x;
        logic [DATA_W-1:0] y;
        errors_before = error_count;
        a = rand_byte();
        x = rand_byte();
        y = rand_byte();
        begin_reset();
        fill_memory();
        set_vector(16'h0500);
        emit(OP_LDA_IMM);
        emit(a);
        emit(OP_STA_ZP);
        emit(8'h80);
        emit(OP_NOP);
        // Not a supported opcode
        emit(8'h02);
        emit(OP_LDY_IMM);
        emit(y);
        emit_jmp(16'h0600);
        prog_ptr = 16'h0600;
        emit(OP_LDX_IMM);
        emit(x);
        emit_halt();
        end_reset();
        next_sync();
        exp_a = a;
        update_nz(exp_a);
        expect_fetch(16'h0502, 2);
        expect_fetch(16'h0504, 3);
        expect_fetch(16'h0505, 2);
        expect_fetch(16'h0506, 2);
        exp_y = y;
        update_nz(exp_y);
        expect_fetch(16'h0508, 2);
        expect_fetch(16'h0600, 3);
        exp_x = x;
        update_nz(exp_x);
        expect_fetch(16'h0602, 2);
        expect_fetch(16'h0602, 3);
        report_test("jumps and timing", errors_before);
    endtask

    initial begin
        i_rst_n = 1'b0;
        test_reset_vector();
        test_loads_transfers();
        test_adc();
        test_logic_stores();
        test_jumps_timing();
        $display("Tests passed: %0d, failed: %0d, check errors: %0d",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
